// File: hw/npc_pkg.sv
// npc core shared types, opcode and csr constants, control enums and reset pc
package npc_pkg;

  // --------------------
  // data widths
  typedef logic [63:0] xlen_t;      // register value, address and pc
  typedef logic [31:0] inst_t;      // raw instruction word
  typedef logic [4:0]  reg_idx_t;   // general register index
  typedef logic [11:0] csr_addr_t;  // csr address field

  // --------------------
  // control encodings
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    PASS_B  // lui passes the u immediate straight through
  } alu_op_e;

  typedef enum logic [1:0] {NONE, EQ, NE, JAL} br_type_e;

  typedef enum logic [1:0] {ALU, MEM, PC4, CSR} wb_sel_e;

  // --------------------
  // constants
  localparam xlen_t RESET_PC   = 64'h0000_0000_8000_0000;
  localparam int    DMEM_WORDS = 64;

  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  localparam csr_addr_t CSR_MEPC  = 12'h341;
  localparam csr_addr_t CSR_MTVEC = 12'h305;

endpackage

// File: hw/npc_ifu.sv
// instruction fetch unit holding the program counter that drives the fetch port
`timescale 1ns/1ps

module npc_ifu (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  logic           i_stall,
  input  npc_pkg::xlen_t i_nextpc,
  output npc_pkg::xlen_t o_pc
);

  npc_pkg::xlen_t pc_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q <= npc_pkg::RESET_PC;
    end else if (!i_stall) begin
      pc_q <= i_nextpc;  // one instruction retires per cycle
    end
  end

  // the fetch address is the pc itself, instruction data comes back in the same cycle
  assign o_pc = pc_q;

endmodule

// File: hw/npc_idu.sv
// instruction decoder with immediate generation and the general register file
`timescale 1ns/1ps

module npc_idu (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  npc_pkg::inst_t       i_inst,
  input  logic                 i_wb_en,
  input  npc_pkg::xlen_t       i_wb_data,
  output npc_pkg::xlen_t       o_rs1,
  output npc_pkg::xlen_t       o_rs2,
  output npc_pkg::xlen_t       o_imm,
  output npc_pkg::reg_idx_t    o_rd,
  output npc_pkg::alu_op_e     o_alu_op,
  output logic                 o_alu_b_imm,
  output npc_pkg::br_type_e    o_br_type,
  output npc_pkg::wb_sel_e     o_wb_sel,
  output logic                 o_reg_wr,
  output logic                 o_mem_rd,
  output logic                 o_mem_wr,
  output logic                 o_csr_wr,
  output npc_pkg::csr_addr_t   o_csr_addr,
  output logic                 o_ecall,
  output logic                 o_mret,
  output logic                 o_invalid
);

  npc_pkg::xlen_t regs [32];
  logic [6:0]     opcode;
  logic [2:0]     funct3;
  logic [6:0]     funct7;
  npc_pkg::xlen_t imm_i;
  npc_pkg::xlen_t imm_s;
  npc_pkg::xlen_t imm_b;
  npc_pkg::xlen_t imm_u;
  npc_pkg::xlen_t imm_j;

  assign opcode     = i_inst[6:0];
  assign funct3     = i_inst[14:12];
  assign funct7     = i_inst[31:25];
  assign o_rd       = i_inst[11:7];
  assign o_csr_addr = i_inst[31:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // --------------------
  // decode
  always_comb begin
    o_imm       = imm_i;
    o_alu_op    = npc_pkg::ADD;
    o_alu_b_imm = 1'b1;
    o_br_type   = npc_pkg::NONE;
    o_wb_sel    = npc_pkg::ALU;
    o_reg_wr    = 1'b0;
    o_mem_rd    = 1'b0;
    o_mem_wr    = 1'b0;
    o_csr_wr    = 1'b0;
    o_ecall     = 1'b0;
    o_mret      = 1'b0;
    o_invalid   = 1'b0;
    case (opcode)
      npc_pkg::OPCODE_OP_IMM: begin
        o_reg_wr  = 1'b1;
        o_invalid = (funct3 != 3'b000);  // addi only
      end
      npc_pkg::OPCODE_OP: begin
        o_alu_b_imm = 1'b0;
        o_reg_wr    = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_alu_op = npc_pkg::ADD;
          10'b0100000_000: o_alu_op = npc_pkg::SUB;
          10'b0000000_111: o_alu_op = npc_pkg::AND;
          10'b0000000_110: o_alu_op = npc_pkg::OR;
          10'b0000000_100: o_alu_op = npc_pkg::XOR;
          default:         o_invalid = 1'b1;
        endcase
      end
      npc_pkg::OPCODE_LUI: begin
        o_imm    = imm_u;
        o_alu_op = npc_pkg::PASS_B;
        o_reg_wr = 1'b1;
      end
      npc_pkg::OPCODE_LOAD: begin
        o_wb_sel  = npc_pkg::MEM;
        o_reg_wr  = 1'b1;
        o_mem_rd  = 1'b1;
        o_invalid = (funct3 != 3'b011);  // ld only
      end
      npc_pkg::OPCODE_STORE: begin
        o_imm     = imm_s;
        o_mem_wr  = 1'b1;
        o_invalid = (funct3 != 3'b011);  // sd only
      end
      npc_pkg::OPCODE_BRANCH: begin
        o_imm     = imm_b;
        o_br_type = funct3[0] ? npc_pkg::NE : npc_pkg::EQ;
        o_invalid = (funct3[2:1] != 2'b00);
      end
      npc_pkg::OPCODE_JAL: begin
        o_imm     = imm_j;
        o_br_type = npc_pkg::JAL;
        o_wb_sel  = npc_pkg::PC4;
        o_reg_wr  = 1'b1;
      end
      npc_pkg::OPCODE_SYSTEM: begin
        if (funct3 == 3'b001) begin
          o_csr_wr  = 1'b1;
          o_reg_wr  = 1'b1;
          o_wb_sel  = npc_pkg::CSR;
          o_invalid = (o_csr_addr != npc_pkg::CSR_MEPC) && (o_csr_addr != npc_pkg::CSR_MTVEC);
        end else begin
          o_ecall   = (i_inst == 32'h0000_0073);
          o_mret    = (i_inst == 32'h3020_0073);
          o_invalid = !(o_ecall || o_mret);
        end
      end
      default: o_invalid = 1'b1;
    endcase
    if (o_invalid) begin  // an illegal word must leave no side effects
      o_br_type = npc_pkg::NONE;
      o_reg_wr  = 1'b0;
      o_mem_rd  = 1'b0;
      o_mem_wr  = 1'b0;
      o_csr_wr  = 1'b0;
      o_ecall   = 1'b0;
      o_mret    = 1'b0;
    end
  end

  // --------------------
  // register file
  assign o_rs1 = regs[i_inst[19:15]];  // x0 is never written so it stays zero
  assign o_rs2 = regs[i_inst[24:20]];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_en && o_reg_wr && (o_rd != '0)) begin
      regs[o_rd] <= i_wb_data;
    end
  end

endmodule

// File: hw/npc_exu.sv
// execute unit with alu, branch resolution, next pc select and write-back mux
`timescale 1ns/1ps

module npc_exu (
  input  npc_pkg::xlen_t    i_pc,
  input  npc_pkg::xlen_t    i_rs1,
  input  npc_pkg::xlen_t    i_rs2,
  input  npc_pkg::xlen_t    i_imm,
  input  npc_pkg::xlen_t    i_csr_rdata,
  input  npc_pkg::xlen_t    i_mem_rdata,
  input  npc_pkg::xlen_t    i_csr_target,
  input  npc_pkg::alu_op_e  i_alu_op,
  input  logic              i_alu_b_imm,
  input  npc_pkg::br_type_e i_br_type,
  input  npc_pkg::wb_sel_e  i_wb_sel,
  input  logic              i_ecall,
  input  logic              i_mret,
  output npc_pkg::xlen_t    o_alu_result,
  output npc_pkg::xlen_t    o_nextpc,
  output npc_pkg::xlen_t    o_wb_data
);

  npc_pkg::xlen_t alu_b;
  npc_pkg::xlen_t pc_plus4;
  npc_pkg::xlen_t br_target;
  logic           taken;

  assign alu_b     = i_alu_b_imm ? i_imm : i_rs2;
  assign pc_plus4  = i_pc + 64'd4;
  assign br_target = i_pc + i_imm;  // b and j immediates are already pc relative

  always_comb begin
    case (i_alu_op)
      npc_pkg::SUB:    o_alu_result = i_rs1 - alu_b;
      npc_pkg::AND:    o_alu_result = i_rs1 & alu_b;
      npc_pkg::OR:     o_alu_result = i_rs1 | alu_b;
      npc_pkg::XOR:    o_alu_result = i_rs1 ^ alu_b;
      npc_pkg::PASS_B: o_alu_result = alu_b;
      default:         o_alu_result = i_rs1 + alu_b;
    endcase
  end

  always_comb begin
    case (i_br_type)
      npc_pkg::EQ:  taken = (i_rs1 == i_rs2);
      npc_pkg::NE:  taken = (i_rs1 != i_rs2);
      npc_pkg::JAL: taken = 1'b1;
      default:      taken = 1'b0;
    endcase
  end

  // traps take priority over the branch path
  assign o_nextpc = (i_ecall || i_mret) ? i_csr_target : (taken ? br_target : pc_plus4);

  always_comb begin
    case (i_wb_sel)
      npc_pkg::MEM: o_wb_data = i_mem_rdata;
      npc_pkg::PC4: o_wb_data = pc_plus4;  // jal link address
      npc_pkg::CSR: o_wb_data = i_csr_rdata;
      default:      o_wb_data = o_alu_result;
    endcase
  end

endmodule

// File: hw/npc_csr.sv
// machine csr file with mepc and mtvec plus ecall and mret trap targets
`timescale 1ns/1ps

module npc_csr (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  npc_pkg::csr_addr_t i_addr,
  input  logic               i_wen,
  input  npc_pkg::xlen_t     i_wdata,
  input  npc_pkg::xlen_t     i_pc,
  input  logic               i_ecall,
  input  logic               i_mret,
  output npc_pkg::xlen_t     o_rdata,
  output npc_pkg::xlen_t     o_target
);

  npc_pkg::xlen_t mepc_q;
  npc_pkg::xlen_t mtvec_q;

  // --------------------
  // read side
  always_comb begin
    case (i_addr)
      npc_pkg::CSR_MEPC:  o_rdata = mepc_q;
      npc_pkg::CSR_MTVEC: o_rdata = mtvec_q;
      default:            o_rdata = '0;
    endcase
  end

  assign o_target = i_mret ? mepc_q : mtvec_q;  // ecall enters the handler at mtvec

  // --------------------
  // update
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mepc_q  <= '0;
      mtvec_q <= '0;
    end else if (i_ecall) begin
      mepc_q <= i_pc;  // handler returns here unless it moves mepc forward
    end else if (i_wen) begin
      if (i_addr == npc_pkg::CSR_MEPC) begin
        mepc_q <= i_wdata;
      end
      if (i_addr == npc_pkg::CSR_MTVEC) begin
        mtvec_q <= i_wdata;
      end
    end
  end

endmodule

// File: hw/npc_lsu.sv
// load/store unit with a small doubleword data memory
`timescale 1ns/1ps

module npc_lsu (
  input  logic           i_clk,
  input  npc_pkg::xlen_t i_addr,
  input  npc_pkg::xlen_t i_wdata,
  input  logic           i_wen,
  input  logic           i_ren,
  output npc_pkg::xlen_t o_rdata
);

  localparam int IDX_W = $clog2(npc_pkg::DMEM_WORDS);

  npc_pkg::xlen_t   mem [npc_pkg::DMEM_WORDS];
  logic [IDX_W-1:0] idx;

  // doubleword index, upper address bits are ignored so accesses wrap
  assign idx = i_addr[3 +: IDX_W];

  // memory powers up cleared, a core reset leaves it alone
  initial begin
    for (int i = 0; i < npc_pkg::DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      mem[idx] <= i_wdata;
    end
  end

  assign o_rdata = i_ren ? mem[idx] : '0;

endmodule

// File: hw/npc_core.sv
// single-cycle rv64 core top connecting fetch, decode, execute, csr and load/store
`timescale 1ns/1ps

module npc_core (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  npc_pkg::inst_t      i_imem_data,
  output npc_pkg::xlen_t      o_imem_addr,
  output logic                o_commit_valid,
  output npc_pkg::xlen_t      o_commit_pc,
  output npc_pkg::reg_idx_t   o_commit_rd,
  output npc_pkg::xlen_t      o_commit_wdata,
  output logic                o_halt
);

  typedef enum logic {ST_RUN, ST_HALT} core_state_e;

  core_state_e        state_q;
  logic               running;
  npc_pkg::xlen_t     pc;
  npc_pkg::xlen_t     nextpc;
  npc_pkg::xlen_t     rs1;
  npc_pkg::xlen_t     rs2;
  npc_pkg::xlen_t     imm;
  npc_pkg::reg_idx_t  rd;
  npc_pkg::alu_op_e   alu_op;
  logic               alu_b_imm;
  npc_pkg::br_type_e  br_type;
  npc_pkg::wb_sel_e   wb_sel;
  logic               reg_wr;
  logic               mem_rd;
  logic               mem_wr;
  logic               csr_wr;
  npc_pkg::csr_addr_t csr_addr;
  logic               ecall;
  logic               mret;
  logic               invalid;
  npc_pkg::xlen_t     alu_result;
  npc_pkg::xlen_t     wb_data;
  npc_pkg::xlen_t     csr_rdata;
  npc_pkg::xlen_t     csr_target;
  npc_pkg::xlen_t     mem_rdata;

  // --------------------
  // run / halt control
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ST_RUN;
    end else begin
      case (state_q)
        ST_RUN:  state_q <= invalid ? ST_HALT : ST_RUN;
        default: state_q <= ST_HALT;  // sticky until the next reset
      endcase
    end
  end

  assign running = (state_q == ST_RUN) && i_rst_n;  // nothing retires while reset is held

  npc_ifu u_ifu (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_stall  (!running || invalid),
    .i_nextpc (nextpc),
    .o_pc     (pc)
  );

  npc_idu u_idu (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_inst      (i_imem_data),
    .i_wb_en     (running),
    .i_wb_data   (wb_data),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_imm       (imm),
    .o_rd        (rd),
    .o_alu_op    (alu_op),
    .o_alu_b_imm (alu_b_imm),
    .o_br_type   (br_type),
    .o_wb_sel    (wb_sel),
    .o_reg_wr    (reg_wr),
    .o_mem_rd    (mem_rd),
    .o_mem_wr    (mem_wr),
    .o_csr_wr    (csr_wr),
    .o_csr_addr  (csr_addr),
    .o_ecall     (ecall),
    .o_mret      (mret),
    .o_invalid   (invalid)
  );

  npc_exu u_exu (
    .i_pc         (pc),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_imm        (imm),
    .i_csr_rdata  (csr_rdata),
    .i_mem_rdata  (mem_rdata),
    .i_csr_target (csr_target),
    .i_alu_op     (alu_op),
    .i_alu_b_imm  (alu_b_imm),
    .i_br_type    (br_type),
    .i_wb_sel     (wb_sel),
    .i_ecall      (ecall),
    .i_mret       (mret),
    .o_alu_result (alu_result),
    .o_nextpc     (nextpc),
    .o_wb_data    (wb_data)
  );

  npc_csr u_csr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_addr   (csr_addr),
    .i_wen    (csr_wr && running),
    .i_wdata  (rs1),              // csrrw writes x[rs1]
    .i_pc     (pc),
    .i_ecall  (ecall && running),
    .i_mret   (mret),
    .o_rdata  (csr_rdata),
    .o_target (csr_target)
  );

  npc_lsu u_lsu (
    .i_clk   (i_clk),
    .i_addr  (alu_result),  // x[rs1] + imm
    .i_wdata (rs2),
    .i_wen   (mem_wr && running),
    .i_ren   (mem_rd),
    .o_rdata (mem_rdata)
  );

  // --------------------
  // fetch port and commit trace
  assign o_imem_addr    = pc;
  assign o_commit_valid = running && !invalid;
  assign o_commit_pc    = pc;
  assign o_commit_rd    = reg_wr ? rd : '0;
  assign o_commit_wdata = (reg_wr && (rd != '0)) ? wb_data : '0;  // x0 writes report zero
  assign o_halt         = (state_q == ST_HALT);

endmodule

// File: verification/npc_properties.sv
// commit port and halt checks bound onto the npc core
`timescale 1ns/1ps

module npc_properties (
  input logic           i_clk,
  input logic           i_rst_n,
  input logic           o_commit_valid,
  input npc_pkg::xlen_t o_commit_pc,
  input logic           o_halt
);

  // a halted core retires nothing
  assert property (@(posedge i_clk) disable iff (!i_rst_n) !(o_commit_valid && o_halt))
    else $error("commit valid and halt are high together");

  assert property (@(posedge i_clk) disable iff (!i_rst_n) o_halt |=> o_halt)
    else $error("halt dropped without a reset");

  assert property (@(posedge i_clk) disable iff (!i_rst_n)
                   o_commit_valid |-> (o_commit_pc[1:0] == 2'b00))
    else $error("commit pc is not word aligned");

endmodule

bind npc_core npc_properties u_props (
  .i_clk          (i_clk),
  .i_rst_n        (i_rst_n),
  .o_commit_valid (o_commit_valid),
  .o_commit_pc    (o_commit_pc),
  .o_halt         (o_halt)
);

// File: verification/npc_tb.sv
// directed testbench for the npc core with an instruction memory and a reference model
`timescale 1ns/1ps

module npc_tb;

  localparam int PROG_WORDS  = 64;
  localparam int MAX_STEPS   = 100;
  localparam int RUNS        = 7;
  localparam int WATCHDOG_NS = RUNS * (16 + 2 + MAX_STEPS + 8) * 8 + 2000;
  localparam logic [31:0] ECALL_W = 32'h0000_0073;
  localparam logic [31:0] MRET_W  = 32'h3020_0073;

  logic               i_clk;
  logic               i_rst_n;
  npc_pkg::inst_t     imem_data;
  npc_pkg::xlen_t     imem_addr;
  npc_pkg::xlen_t     imem_idx;
  logic               commit_valid;
  npc_pkg::xlen_t     commit_pc;
  npc_pkg::reg_idx_t  commit_rd;
  npc_pkg::xlen_t     commit_wdata;
  logic               halt;

  logic [31:0]        prog [PROG_WORDS];
  int                 plen;
  npc_pkg::xlen_t     m_mem [npc_pkg::DMEM_WORDS];  // model memory survives resets like the DUT's
  npc_pkg::xlen_t     exp_pc [$];
  npc_pkg::xlen_t     exp_rd [$];
  npc_pkg::xlen_t     exp_wd [$];
  npc_pkg::xlen_t     got_pc [$];
  npc_pkg::xlen_t     got_rd [$];
  npc_pkg::xlen_t     got_wd [$];
  npc_pkg::xlen_t     halt_pc;
  logic [15:0]        lfsr;
  int                 errors;
  int                 tests;
  int                 failed_tests;

  npc_core uut (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_imem_data    (imem_data),
    .o_imem_addr    (imem_addr),
    .o_commit_valid (commit_valid),
    .o_commit_pc    (commit_pc),
    .o_commit_rd    (commit_rd),
    .o_commit_wdata (commit_wdata),
    .o_halt         (halt)
  );

  // words past the program read as zero, which is an illegal encoding
  assign imem_idx  = (imem_addr - npc_pkg::RESET_PC) >> 2;
  assign imem_data = (imem_idx < PROG_WORDS) ? prog[imem_idx[5:0]] : 32'h0;

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Regression failed");
    $finish;
  end

  always @(negedge i_clk) begin
    if (commit_valid) begin
      got_pc.push_back(commit_pc);
      got_rd.push_back(64'(commit_rd));
      got_wd.push_back(commit_wdata);
    end
  end

  // --------------------
  // stimulus helpers
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [11:0] rand_imm12();
    logic [11:0] v;
    for (int i = 0; i < 12; i++) begin
      v[i] = lfsr_bit();
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, npc_pkg::OPCODE_OP};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], npc_pkg::OPCODE_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], npc_pkg::OPCODE_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, npc_pkg::OPCODE_JAL};
  endfunction

  task automatic put(logic [31:0] w);
    prog[plen] = w;
    plen++;
  endtask

  task automatic new_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = 32'h0;
    end
    plen = 0;
  endtask

  task automatic expect_equal(string what, npc_pkg::xlen_t got, npc_pkg::xlen_t exp);
    assert (got === exp) else begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // --------------------
  // reference model that executes the program by the ISA rules up to the first illegal word
  task automatic model_run();
    npc_pkg::xlen_t x [32];
    npc_pkg::xlen_t pc;
    npc_pkg::xlen_t a;
    npc_pkg::xlen_t b;
    npc_pkg::xlen_t wd;
    npc_pkg::xlen_t npc;
    npc_pkg::xlen_t mepc;
    npc_pkg::xlen_t mtvec;
    npc_pkg::xlen_t immi;
    npc_pkg::xlen_t ea;
    npc_pkg::xlen_t widx;
    logic [31:0]    w;
    logic           wr;
    logic           ok;
    x = '{default: '0};
    pc = npc_pkg::RESET_PC;
    mepc = '0;
    mtvec = '0;
    exp_pc.delete();
    exp_rd.delete();
    exp_wd.delete();
    for (int n = 0; n < MAX_STEPS; n++) begin
      widx = (pc - npc_pkg::RESET_PC) >> 2;
      w    = (widx < PROG_WORDS) ? prog[widx[5:0]] : 0;
      a    = x[w[19:15]];
      b    = x[w[24:20]];
      immi = {{52{w[31]}}, w[31:20]};
      ea   = a + immi;
      wr   = 1'b1;
      ok   = 1'b1;
      wd   = '0;
      npc  = pc + 4;
      case (w[6:0])
        npc_pkg::OPCODE_OP_IMM: begin
          ok = (w[14:12] == 3'b000);
          wd = a + immi;
        end
        npc_pkg::OPCODE_OP: begin
          case ({w[31:25], w[14:12]})
            10'b0000000_000: wd = a + b;
            10'b0100000_000: wd = a - b;
            10'b0000000_111: wd = a & b;
            10'b0000000_110: wd = a | b;
            10'b0000000_100: wd = a ^ b;
            default:         ok = 1'b0;
          endcase
        end
        npc_pkg::OPCODE_LUI: wd = {{32{w[31]}}, w[31:12], 12'b0};
        npc_pkg::OPCODE_LOAD: begin
          ok = (w[14:12] == 3'b011);
          wd = m_mem[ea[8:3]];
        end
        npc_pkg::OPCODE_STORE: begin
          wr = 1'b0;
          ok = (w[14:12] == 3'b011);
          ea = a + {{52{w[31]}}, w[31:25], w[11:7]};
          if (ok) m_mem[ea[8:3]] = b;
        end
        npc_pkg::OPCODE_BRANCH: begin
          wr = 1'b0;
          ok = (w[14:13] == 2'b00);
          if ((w[12] == 1'b0) ? (a == b) : (a != b)) begin
            npc = pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        npc_pkg::OPCODE_JAL: begin
          wd  = pc + 4;
          npc = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        npc_pkg::OPCODE_SYSTEM: begin
          if (w[14:12] == 3'b001 && w[31:20] == npc_pkg::CSR_MEPC) begin
            wd   = mepc;
            mepc = a;
          end else if (w[14:12] == 3'b001 && w[31:20] == npc_pkg::CSR_MTVEC) begin
            wd    = mtvec;
            mtvec = a;
          end else if (w == ECALL_W) begin
            wr   = 1'b0;
            mepc = pc;
            npc  = mtvec;
          end else if (w == MRET_W) begin
            wr  = 1'b0;
            npc = mepc;
          end else begin
            ok = 1'b0;
          end
        end
        default: ok = 1'b0;
      endcase
      if (!ok) break;
      exp_pc.push_back(pc);
      exp_rd.push_back(wr ? 64'(w[11:7]) : 64'd0);
      exp_wd.push_back((wr && w[11:7] != 0) ? wd : 64'd0);
      if (wr && w[11:7] != 0) x[w[11:7]] = wd;
      pc = npc;
    end
    halt_pc = pc;
  endtask

  // --------------------
  // run the loaded program on a freshly reset core and compare the commit stream
  task automatic run_program();
    int cycles;
    model_run();
    @(posedge i_clk);
    i_rst_n <= 1'b0;
    repeat (15) @(posedge i_clk);
    @(negedge i_clk);
    expect_equal("commit valid during reset", 64'(commit_valid), 64'd0);
    expect_equal("halt during reset", 64'(halt), 64'd0);
    @(posedge i_clk);
    got_pc.delete();
    got_rd.delete();
    got_wd.delete();
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    expect_equal("halt after reset", 64'(halt), 64'd0);
    expect_equal("commit valid after reset", 64'(commit_valid), 64'd1);
    cycles = 0;
    while (!halt && cycles < MAX_STEPS + 4) begin
      @(negedge i_clk);
      cycles++;
    end
    assert (halt) else begin
      $display("core never raised halt at the end of the program");
      errors++;
    end
    repeat (4) begin
      @(negedge i_clk);
      expect_equal("fetch address while halted", imem_addr, halt_pc);
      expect_equal("halt level", 64'(halt), 64'd1);
    end
    expect_equal("commit count", 64'(got_pc.size()), 64'(exp_pc.size()));
    for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
      expect_equal($sformatf("commit %0d pc", i), got_pc[i], exp_pc[i]);
      expect_equal($sformatf("commit %0d rd", i), got_rd[i], exp_rd[i]);
      expect_equal($sformatf("commit %0d wdata", i), got_wd[i], exp_wd[i]);
    end
  endtask

  task automatic report_test(string name, int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // --------------------
  // directed tests
  task automatic test_arith();
    int e0;
    logic [11:0] r;
    e0 = errors;
    new_program();
    for (int k = 0; k < 3; k++) begin
      r = rand_imm12();
      put(enc_i(r, 5'd0, 3'b000, 5'd1, npc_pkg::OPCODE_OP_IMM));
      put(enc_i(rand_imm12(), 5'd0, 3'b000, 5'd2, npc_pkg::OPCODE_OP_IMM));
      put(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
      put(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
      put(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
      put(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
      put(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
      put({r, r[7:0], 5'd8, npc_pkg::OPCODE_LUI});
      put(enc_i(r, 5'd1, 3'b000, 5'd0, npc_pkg::OPCODE_OP_IMM));  // write to x0
      put(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
    end
    run_program();
    report_test("arith", e0);
  endtask

  task automatic test_memory();
    int e0;
    e0 = errors;
    new_program();
    put(enc_i(12'h040, 5'd0, 3'b000, 5'd1, npc_pkg::OPCODE_OP_IMM));
    put(enc_i(rand_imm12(), 5'd0, 3'b000, 5'd2, npc_pkg::OPCODE_OP_IMM));
    put({rand_imm12(), 8'h5a, 5'd3, npc_pkg::OPCODE_LUI});
    put(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd2));
    put(enc_s(12'h000, 5'd2, 5'd1));
    put(enc_i(12'h000, 5'd1, 3'b011, 5'd4, npc_pkg::OPCODE_LOAD));
    put(enc_i(12'h200, 5'd1, 3'b011, 5'd5, npc_pkg::OPCODE_LOAD));  // wraps onto the same word
    put(enc_i(12'h100, 5'd1, 3'b011, 5'd6, npc_pkg::OPCODE_LOAD));  // never written
    run_program();
    report_test("memory", e0);
  endtask

  task automatic test_control();
    int e0;
    e0 = errors;
    new_program();
    put(enc_i(12'd5, 5'd0, 3'b000, 5'd1, npc_pkg::OPCODE_OP_IMM));
    put(enc_i(12'd5, 5'd0, 3'b000, 5'd2, npc_pkg::OPCODE_OP_IMM));
    put(enc_b(13'd8, 5'd2, 5'd1, 3'b000));  // taken beq
    put(enc_i(12'd1, 5'd0, 3'b000, 5'd3, npc_pkg::OPCODE_OP_IMM));
    put(enc_b(13'd8, 5'd2, 5'd1, 3'b001));  // untaken bne
    put(enc_i(12'd2, 5'd0, 3'b000, 5'd4, npc_pkg::OPCODE_OP_IMM));
    put(enc_j(21'd8, 5'd5));
    put(enc_i(12'd3, 5'd0, 3'b000, 5'd6, npc_pkg::OPCODE_OP_IMM));
    put(enc_b(13'd8, 5'd0, 5'd1, 3'b000));  // untaken beq
    put(enc_b(13'd8, 5'd0, 5'd1, 3'b001));  // taken bne
    put(enc_i(12'd4, 5'd0, 3'b000, 5'd7, npc_pkg::OPCODE_OP_IMM));
    put(enc_i(12'd9, 5'd0, 3'b000, 5'd8, npc_pkg::OPCODE_OP_IMM));
    run_program();
    report_test("control", e0);
  endtask

  task automatic test_trap();
    int e0;
    e0 = errors;
    new_program();
    put({20'h40000, 5'd1, npc_pkg::OPCODE_LUI});
    put(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd1));
    put(enc_i(12'd40, 5'd1, 3'b000, 5'd1, npc_pkg::OPCODE_OP_IMM));  // handler at word 10
    put(enc_i(npc_pkg::CSR_MTVEC, 5'd1, 3'b001, 5'd2, npc_pkg::OPCODE_SYSTEM));
    put(enc_i(npc_pkg::CSR_MTVEC, 5'd1, 3'b001, 5'd3, npc_pkg::OPCODE_SYSTEM));
    put(ECALL_W);
    put(enc_i(12'd7, 5'd0, 3'b000, 5'd4, npc_pkg::OPCODE_OP_IMM));
    plen = 10;
    put(enc_i(npc_pkg::CSR_MEPC, 5'd0, 3'b001, 5'd5, npc_pkg::OPCODE_SYSTEM));
    put(enc_i(12'd4, 5'd5, 3'b000, 5'd5, npc_pkg::OPCODE_OP_IMM));
    put(enc_i(npc_pkg::CSR_MEPC, 5'd5, 3'b001, 5'd0, npc_pkg::OPCODE_SYSTEM));
    put(MRET_W);
    run_program();
    report_test("trap", e0);
  endtask

  task automatic test_halt();
    int e0;
    e0 = errors;
    new_program();
    put(enc_i(12'h080, 5'd0, 3'b000, 5'd1, npc_pkg::OPCODE_OP_IMM));
    put(enc_i(rand_imm12(), 5'd0, 3'b000, 5'd2, npc_pkg::OPCODE_OP_IMM));
    put(enc_s(12'h000, 5'd2, 5'd1));
    put(32'hffff_ffff);
    put(enc_i(12'h001, 5'd0, 3'b000, 5'd3, npc_pkg::OPCODE_OP_IMM));
    run_program();
    // the stored word must still be there after a fresh reset
    new_program();
    put(enc_i(12'h080, 5'd0, 3'b000, 5'd1, npc_pkg::OPCODE_OP_IMM));
    put(enc_i(12'h000, 5'd1, 3'b011, 5'd4, npc_pkg::OPCODE_LOAD));
    run_program();
    report_test("halt", e0);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    new_program();
    put(enc_i(12'h123, 5'd0, 3'b000, 5'd1, npc_pkg::OPCODE_OP_IMM));
    run_program();
    expect_equal("first commit pc", (got_pc.size() > 0) ? got_pc[0] : '1, npc_pkg::RESET_PC);
    report_test("reset", e0);
  endtask

  initial begin
    i_rst_n      = 1'b0;
    lfsr         = 16'd39656;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    for (int i = 0; i < npc_pkg::DMEM_WORDS; i++) begin
      m_mem[i] = '0;
    end
    new_program();
    test_reset();
    test_arith();
    test_memory();
    test_control();
    test_trap();
    test_halt();
    $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: sim.f
hw/npc_pkg.sv
hw/npc_ifu.sv
hw/npc_idu.sv
hw/npc_exu.sv
hw/npc_csr.sv
hw/npc_lsu.sv
hw/npc_core.sv
verification/npc_properties.sv
verification/npc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the npc core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module npc_tb -o npc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/npc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
